// File: project.f
+incdir+.
ed25519_pkg.sv
field_mul.sv
point_sequencer.sv
point_datapath.sv
result_serializer.sv
point_mul_top.sv
point_mul_properties.sv
tb_point_mul.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the point multiplier testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_point_mul -f project.f

./obj_dir/Vtb_point_mul | tee sim.log

if grep -qx "PASS: all tests" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: tb_point_mul.sv
`default_nettype none
`include "ed25519_config.svh"

module tb_point_mul;

	timeunit 1ns;
	timeprecision 1ps;

	import ed25519_pkg::*;

	localparam int NUM_ROWS = 6;
	localparam fe_t Q = `FIELD_Q;
	// base point B, affine
	localparam fe_t BASE_X = 256'h216936d3cd6e53fec0a4e231fdd6dc5c692cc7609525a7b2c9562d608f25d51a;
	localparam fe_t BASE_Y = 256'h6666666666666666666666666666666666666666666666666666666666666658;

	logic i_clk;
	logic i_rst;
	logic i_start;
	fe_t i_scalar;
	fe_t i_px;
	fe_t i_py;
	logic i_out_ready;
	logic o_ready;
	logic o_out_valid;
	logic [`OUT_W-1:0] o_out_data;

	// stimulus table, expected point given before the odd-x rule
	string row_name [NUM_ROWS];
	fe_t row_scalar [NUM_ROWS];
	fe_t row_px [NUM_ROWS];
	fe_t row_py [NUM_ROWS];
	fe_t row_ex [NUM_ROWS];
	fe_t row_ey [NUM_ROWS];

	integer seed;
	int errors;
	int tests_failed;

	point_mul_top dut_i
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_start     (i_start),
		.i_scalar    (i_scalar),
		.i_px        (i_px),
		.i_py        (i_py),
		.o_ready     (o_ready),
		.i_out_ready (i_out_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	bind point_mul_top point_mul_properties props_i
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_start     (i_start),
		.o_ready     (o_ready),
		.i_out_ready (i_out_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	task automatic set_row(input int r, input string name, input fe_t k, input fe_t px,
		input fe_t py, input fe_t ex, input fe_t ey);
		row_name[r] = name;
		row_scalar[r] = k;
		row_px[r] = px;
		row_py[r] = py;
		row_ex[r] = ex;
		row_ey[r] = ey;
	endtask

	task automatic fill_table();
		set_row(0, "0 * B", fe_t'(0), BASE_X, BASE_Y, fe_t'(0), fe_t'(1));
		set_row(1, "1 * B", fe_t'(1), BASE_X, BASE_Y, BASE_X, BASE_Y);
		set_row(2, "5 * identity", fe_t'(5), fe_t'(0), fe_t'(1), fe_t'(0), fe_t'(1));
		set_row(3, "3 * order-2 point", fe_t'(3), fe_t'(0), Q - 1, fe_t'(0), Q - 1);
		set_row(4, "2 * order-2 point", fe_t'(2), fe_t'(0), Q - 1, fe_t'(0), fe_t'(1));
		set_row(5, "(2^255 + 1) * B", {1'b1, 255'd1}, BASE_X, BASE_Y, BASE_X, BASE_Y);
	endtask

	// output x is kept even, odd x becomes q - x
	function automatic fe_t even_x(input fe_t x);
		if (x[0])
		begin
			return Q - x;
		end
		return x;
	endfunction

	task automatic check_value(input string name, input fe_t got, input fe_t exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic start_row(input int r);
		@(posedge i_clk);
		while (!o_ready)
		begin
			@(posedge i_clk);
		end
		i_start <= 1'b1;
		i_scalar <= row_scalar[r];
		i_px <= row_px[r];
		i_py <= row_py[r];
		@(posedge i_clk); // taken on this edge
		i_start <= 1'b0;
	endtask

	// gathers eight words while the sink stalls at random
	task automatic collect_result(output fe_t got_x, output fe_t got_y);
		logic [2*`FE_W-1:0] words;
		int n;
		words = '0;
		n = 0;
		while (n < `OUT_WORDS)
		begin
			@(posedge i_clk);
			if (o_out_valid && i_out_ready)
			begin
				words = {words[2*`FE_W-`OUT_W-1:0], o_out_data};
				n++;
			end
			i_out_ready <= (($random(seed) & 3) != 0); // stall about one cycle in four
		end
		{got_x, got_y} = words;
	endtask

	// no ninth word, and back in idle
	task automatic check_after_last();
		int extra;
		extra = 0;
		i_out_ready <= 1'b1;
		@(posedge i_clk);
		check_value("o_ready", fe_t'(o_ready), fe_t'(1));
		for (int k = 0; k < 4; k++)
		begin
			if (o_out_valid)
			begin
				extra++;
			end
			@(posedge i_clk);
		end
		check_value("o_out_valid cycles after the eighth word", fe_t'(extra), fe_t'(0));
	endtask

	initial
	begin
		int row_err;
		fe_t got_x;
		fe_t got_y;
		seed = 32'h7206;
		errors = 0;
		tests_failed = 0;
		i_rst = 1'b1;
		i_start = 1'b0;
		i_scalar = '0;
		i_px = '0;
		i_py = '0;
		i_out_ready = 1'b1;
		fill_table();
		repeat (5) @(posedge i_clk);
		i_rst <= 1'b0;
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			row_err = errors;
			start_row(r);
			collect_result(got_x, got_y);
			check_value("o_out_data x words", got_x, even_x(row_ex[r]));
			check_value("o_out_data y words", got_y, row_ey[r]);
			check_after_last();
			if (errors != row_err)
			begin
				tests_failed++;
			end
			$display("test %0d %s: %s", r, row_name[r], (errors == row_err) ? "ok" : "failed");
		end
		$display("%0d tests, %0d failed, %0d errors", NUM_ROWS, tests_failed, errors);
		if (errors == 0)
		begin
			$display("PASS: all tests");
		end
		else
		begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	// watchdog, twice the longest run counted in 8 ns cycles
	initial
	begin
		longint limit;
		limit = 64'(NUM_ROWS) * (255 * (`DBL_STEPS + `ADD_STEPS) + 2 * `INV_BITS + 2)
			* (`FE_W + 2) * 2;
		repeat (limit) @(posedge i_clk);
		$display("timeout after %0d cycles, the DUT did not deliver all results", limit);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// File: point_mul_properties.sv
`default_nettype none
`include "ed25519_config.svh"

module point_mul_properties
(
	input logic               i_clk,
	input logic               i_rst,
	input logic               i_start,
	input logic               o_ready,
	input logic               i_out_ready,
	input logic               o_out_valid,
	input logic [`OUT_W-1:0]  o_out_data
);

	timeunit 1ns;
	timeprecision 1ps;

	// word held while the sink stalls
	a_stall_stable: assert property (@(posedge i_clk) disable iff (i_rst)
		o_out_valid && !i_out_ready |=> o_out_valid && $stable(o_out_data))
	else $error("output word changed while i_out_ready was low");

	a_valid_after_reset: assert property (@(posedge i_clk)
		i_rst |=> !o_out_valid)
	else $error("o_out_valid high in the cycle after reset");

	// a start only counts in idle
	a_start_leaves_idle: assert property (@(posedge i_clk) disable iff (i_rst)
		i_start && o_ready |=> !o_ready)
	else $error("start seen with o_ready high but the DUT stayed idle");

	a_idle_needs_start: assert property (@(posedge i_clk) disable iff (i_rst)
		o_ready && !i_start |=> o_ready)
	else $error("DUT left idle without a start");

endmodule

`default_nettype wire

// File: point_mul_top.sv
`default_nettype none
`include "ed25519_config.svh"

module point_mul_top
(
	input  logic               i_clk,
	input  logic               i_rst,
	input  logic               i_start,
	input  ed25519_pkg::fe_t   i_scalar,
	input  ed25519_pkg::fe_t   i_px,
	input  ed25519_pkg::fe_t   i_py,
	output logic               o_ready,
	input  logic               i_out_ready,
	output logic               o_out_valid,
	output logic [`OUT_W-1:0]  o_out_data
);

	import ed25519_pkg::*;

	logic load;
	logic mul_start;
	logic mul_done;
	logic emit_done;
	logic aff_valid;
	phase_t phase;
	logic [3:0] step;
	fe_t mul_a, mul_b, product;
	fe_t aff_x, aff_y;

	point_sequencer u_seq
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_start     (i_start),
		.i_scalar    (i_scalar),
		.i_mul_done  (mul_done),
		.i_emit_done (emit_done),
		.o_ready     (o_ready),
		.o_load      (load),
		.o_mul_start (mul_start),
		.o_phase     (phase),
		.o_step      (step)
	);

	point_datapath u_dp
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_load      (load),
		.i_px        (i_px),
		.i_py        (i_py),
		.i_phase     (phase),
		.i_step      (step),
		.i_mul_done  (mul_done),
		.i_product   (product),
		.o_mul_a     (mul_a),
		.o_mul_b     (mul_b),
		.o_aff_x     (aff_x),
		.o_aff_y     (aff_y),
		.o_aff_valid (aff_valid)
	);

	field_mul u_mul
	(
		.i_clk     (i_clk),
		.i_rst     (i_rst),
		.i_start   (mul_start),
		.i_a       (mul_a),
		.i_b       (mul_b),
		.o_done    (mul_done),
		.o_product (product)
	);

	result_serializer u_ser
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_aff_valid (aff_valid),
		.i_aff_x     (aff_x),
		.i_aff_y     (aff_y),
		.i_out_ready (i_out_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data),
		.o_emit_done (emit_done)
	);

endmodule

`default_nettype wire

// File: result_serializer.sv
`default_nettype none
`include "ed25519_config.svh"

module result_serializer
(
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_aff_valid,
	input  ed25519_pkg::fe_t     i_aff_x,
	input  ed25519_pkg::fe_t     i_aff_y,
	input  logic                 i_out_ready,
	output logic                 o_out_valid,
	output logic [`OUT_W-1:0]    o_out_data,
	output logic                 o_emit_done
);

	import ed25519_pkg::*;

	localparam int CNT_W = $clog2(`OUT_WORDS);

	fe_t sr_x, sr_y; // x drains first, y follows behind it
	logic [CNT_W-1:0] cnt_q;
	logic valid_q;
	logic xfer;

	assign xfer = valid_q & i_out_ready;
	assign o_out_valid = valid_q;
	assign o_out_data = sr_x[`FE_W-1 -: `OUT_W];
	assign o_emit_done = xfer && (cnt_q == CNT_W'(`OUT_WORDS - 1)); // last word

	always_ff @(posedge i_clk)
	begin
		if (i_aff_valid)
		begin
			{sr_x, sr_y} <= {i_aff_x, i_aff_y};
		end
		else if (xfer)
		begin
			{sr_x, sr_y} <= {sr_x, sr_y} << `OUT_W;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			valid_q <= 1'b0;
			cnt_q <= '0;
		end
		else if (i_aff_valid)
		begin
			valid_q <= 1'b1;
			cnt_q <= '0;
		end
		else if (xfer)
		begin
			cnt_q <= cnt_q + 1'b1;
			if (o_emit_done)
			begin
				valid_q <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: point_datapath.sv
`default_nettype none
`include "ed25519_config.svh"

module point_datapath
(
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_load,
	input  ed25519_pkg::fe_t     i_px,
	input  ed25519_pkg::fe_t     i_py,
	input  ed25519_pkg::phase_t  i_phase,
	input  logic [3:0]           i_step,
	input  logic                 i_mul_done,
	input  ed25519_pkg::fe_t     i_product,
	output ed25519_pkg::fe_t     o_mul_a,
	output ed25519_pkg::fe_t     o_mul_b,
	output ed25519_pkg::fe_t     o_aff_x,
	output ed25519_pkg::fe_t     o_aff_y,
	output logic                 o_aff_valid
);

	import ed25519_pkg::*;

	localparam fe_t FE_ONE = fe_t'(1);

	fe_t x_q, y_q, z_q; // accumulator, affine result after AFFINE
	fe_t px_q, py_q;
	fe_t inv_q; // running z^(q-2)
	fe_t r1_q, r2_q, r3_q, r4_q;
	fe_t pxy; // px + py
	logic aff_valid_q;

	assign o_aff_x = x_q;
	assign o_aff_y = y_q;
	assign o_aff_valid = aff_valid_q;

	assign pxy = fe_add(px_q, py_q);

	// operand select
	always_comb
	begin
		o_mul_a = '0;
		o_mul_b = '0;
		case (i_phase)
			DOUBLE:
			begin
				case (i_step)
					4'd0: {o_mul_a, o_mul_b} = {x_q, x_q}; // C
					4'd1: {o_mul_a, o_mul_b} = {y_q, y_q}; // D
					4'd2: {o_mul_a, o_mul_b} = {z_q, z_q}; // H
					4'd3: {o_mul_a, o_mul_b} = {r2_q, r2_q}; // B
					4'd4: {o_mul_a, o_mul_b} = {r2_q, r1_q}; // (B-C-D)*J
					4'd5: {o_mul_a, o_mul_b} = {r3_q, r4_q}; // F*(E-D)
					4'd6: {o_mul_a, o_mul_b} = {r3_q, r1_q}; // F*J
					default: ;
				endcase
			end
			ADD:
			begin
				case (i_step)
					4'd0: {o_mul_a, o_mul_b} = {x_q, px_q}; // C
					4'd1: {o_mul_a, o_mul_b} = {y_q, py_q}; // D
					4'd2: {o_mul_a, o_mul_b} = {`CURVE_D, r1_q};
					4'd3: {o_mul_a, o_mul_b} = {r1_q, r4_q}; // E
					4'd4: {o_mul_a, o_mul_b} = {z_q, z_q}; // B, A is z since Z2 = 1
					4'd5: {o_mul_a, o_mul_b} = {r2_q, pxy};
					4'd6: {o_mul_a, o_mul_b} = {z_q, r4_q}; // A*F
					4'd7: {o_mul_a, o_mul_b} = {x_q, r2_q}; // X3
					4'd8: {o_mul_a, o_mul_b} = {z_q, r1_q}; // A*G
					4'd9: {o_mul_a, o_mul_b} = {r2_q, r3_q}; // Y3
					4'd10: {o_mul_a, o_mul_b} = {r4_q, r1_q}; // Z3
					default: ;
				endcase
			end
			INVERT:
			begin
				o_mul_a = inv_q;
				o_mul_b = (i_step == 4'd0) ? inv_q : z_q; // square, or times z
			end
			AFFINE:
			begin
				o_mul_a = (i_step == 4'd0) ? x_q : y_q;
				o_mul_b = inv_q;
			end
			default: ;
		endcase
	end

	// write-back
	always_ff @(posedge i_clk)
	begin
		if (i_load)
		begin
			x_q <= '0; // identity
			y_q <= FE_ONE;
			z_q <= FE_ONE;
			px_q <= i_px;
			py_q <= i_py;
			inv_q <= FE_ONE;
		end
		else if (i_mul_done)
		begin
			case (i_phase)
				DOUBLE:
				begin
					case (i_step)
						4'd0:
						begin
							r1_q <= fe_sub('0, i_product); // E = -C
							r2_q <= fe_add(x_q, y_q);
						end
						4'd1:
						begin
							r3_q <= fe_add(r1_q, i_product); // F
							r4_q <= fe_sub(r1_q, i_product); // E - D
						end
						4'd2: r1_q <= fe_sub(r3_q, fe_add(i_product, i_product)); // J
						4'd3: r2_q <= fe_add(i_product, r4_q); // B - C - D
						4'd4: x_q <= i_product;
						4'd5: y_q <= i_product;
						4'd6: z_q <= i_product;
						default: ;
					endcase
				end
				ADD:
				begin
					case (i_step)
						4'd0:
						begin
							r1_q <= i_product;
							r2_q <= fe_add(x_q, y_q);
						end
						4'd1:
						begin
							r3_q <= fe_add(r1_q, i_product); // C + D
							r4_q <= i_product;
						end
						4'd2: r1_q <= i_product; // d*C
						4'd3: r1_q <= i_product; // E
						4'd4:
						begin
							r4_q <= fe_sub(i_product, r1_q); // F
							r1_q <= fe_add(i_product, r1_q); // G
						end
						4'd5: r2_q <= fe_sub(i_product, r3_q);
						4'd6: x_q <= i_product; // x reused as scratch
						4'd7: x_q <= i_product;
						4'd8: r2_q <= i_product;
						4'd9: y_q <= i_product;
						4'd10: z_q <= i_product;
						default: ;
					endcase
				end
				INVERT:
				begin
					inv_q <= i_product;
				end
				AFFINE:
				begin
					if (i_step == 4'd0)
					begin
						x_q <= i_product[0] ? fe_sub('0, i_product) : i_product; // even x
					end
					else
					begin
						y_q <= i_product;
					end
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			aff_valid_q <= 1'b0;
		end
		else
		begin
			aff_valid_q <= i_mul_done && (i_phase == AFFINE) && (i_step == 4'd1);
		end
	end

endmodule

`default_nettype wire

// File: point_sequencer.sv
`default_nettype none
`include "ed25519_config.svh"

module point_sequencer
(
	input  logic                 i_clk,
	input  logic                 i_rst,
	input  logic                 i_start,
	input  ed25519_pkg::fe_t     i_scalar,
	input  logic                 i_mul_done,
	input  logic                 i_emit_done,
	output logic                 o_ready,
	output logic                 o_load,
	output logic                 o_mul_start,
	output ed25519_pkg::phase_t  o_phase,
	output logic [3:0]           o_step
);

	import ed25519_pkg::*;

	localparam int IDX_W = $clog2(`FE_W);
	localparam logic [3:0] DBL_LAST = 4'(`DBL_STEPS - 1);
	localparam logic [3:0] ADD_LAST = 4'(`ADD_STEPS - 1);
	localparam logic [3:0] AFF_LAST = 4'd1; // x then y
	localparam fe_t INV_EXP = `FIELD_Q - 2;
	localparam logic [IDX_W-1:0] SCALAR_TOP = IDX_W'(`FE_W - 2); // bit 255 skipped
	localparam logic [IDX_W-1:0] EXP_TOP = IDX_W'(`INV_BITS - 1);

	phase_t phase_q;
	logic [3:0] step_q;
	logic [IDX_W-1:0] idx_q; // scalar bit, then exponent bit
	fe_t scalar_q;
	logic start_q;

	assign o_ready = (phase_q == IDLE);
	assign o_load = o_ready & i_start;
	assign o_mul_start = start_q;
	assign o_phase = phase_q;
	assign o_step = step_q;

	always_ff @(posedge i_clk)
	begin
		if (o_load)
		begin
			scalar_q <= i_scalar;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			phase_q <= IDLE;
			step_q <= '0;
			idx_q <= '0;
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= 1'b0;
			case (phase_q)
				IDLE:
				begin
					if (o_load)
					begin
						phase_q <= DOUBLE;
						step_q <= '0;
						idx_q <= SCALAR_TOP;
						start_q <= 1'b1;
					end
				end
				DOUBLE:
				begin
					if (i_mul_done)
					begin
						start_q <= 1'b1;
						if (step_q != DBL_LAST)
						begin
							step_q <= step_q + 1'b1;
						end
						else
						begin
							step_q <= '0;
							if (scalar_q[idx_q])
							begin
								phase_q <= ADD; // same bit, add P
							end
							else if (idx_q == '0)
							begin
								phase_q <= INVERT;
								idx_q <= EXP_TOP;
							end
							else
							begin
								idx_q <= idx_q - 1'b1;
							end
						end
					end
				end
				ADD:
				begin
					if (i_mul_done)
					begin
						start_q <= 1'b1;
						if (step_q != ADD_LAST)
						begin
							step_q <= step_q + 1'b1;
						end
						else
						begin
							step_q <= '0;
							if (idx_q == '0)
							begin
								phase_q <= INVERT;
								idx_q <= EXP_TOP;
							end
							else
							begin
								phase_q <= DOUBLE;
								idx_q <= idx_q - 1'b1;
							end
						end
					end
				end
				INVERT:
				begin
					if (i_mul_done)
					begin
						start_q <= 1'b1;
						if (step_q == 4'd0 && INV_EXP[idx_q])
						begin
							step_q <= 4'd1; // multiply after the square
						end
						else
						begin
							step_q <= '0;
							if (idx_q == '0)
							begin
								phase_q <= AFFINE;
							end
							else
							begin
								idx_q <= idx_q - 1'b1;
							end
						end
					end
				end
				AFFINE:
				begin
					if (i_mul_done)
					begin
						if (step_q != AFF_LAST)
						begin
							step_q <= step_q + 1'b1;
							start_q <= 1'b1;
						end
						else
						begin
							phase_q <= EMIT; // no multiply from here on
							step_q <= '0;
						end
					end
				end
				EMIT:
				begin
					if (i_emit_done)
					begin
						phase_q <= IDLE;
					end
				end
				default:
				begin
					phase_q <= IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: field_mul.sv
`default_nettype none
`include "ed25519_config.svh"

module field_mul
(
	input  logic              i_clk,
	input  logic              i_rst,
	input  logic              i_start,
	input  ed25519_pkg::fe_t  i_a,
	input  ed25519_pkg::fe_t  i_b,
	output logic              o_done,
	output ed25519_pkg::fe_t  o_product
);

	import ed25519_pkg::*;

	localparam int CNT_W = $clog2(`FE_W);

	fe_t a_q;
	fe_t b_q; // shifted left, msb is the live bit
	fe_t acc_q;
	fe_t acc_dbl;
	fe_t acc_next;
	logic busy_q;
	logic done_q;
	logic [CNT_W-1:0] cnt_q;

	assign o_done = done_q;
	assign o_product = acc_q;

	// double and add, one bit of b per cycle
	always_comb
	begin
		acc_dbl = fe_add(acc_q, acc_q);
		acc_next = b_q[`FE_W-1] ? fe_add(acc_dbl, a_q) : acc_dbl;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			cnt_q <= '0;
		end
		else
		begin
			done_q <= 1'b0;
			if (i_start)
			begin
				busy_q <= 1'b1; // load cycle
				cnt_q <= '0;
			end
			else if (busy_q)
			begin
				cnt_q <= cnt_q + 1'b1;
				if (cnt_q == CNT_W'(`FE_W - 1))
				begin
					busy_q <= 1'b0;
					done_q <= 1'b1; // product settles with this edge
				end
			end
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (i_start)
		begin
			a_q <= i_a;
			b_q <= i_b;
			acc_q <= '0;
		end
		else if (busy_q)
		begin
			acc_q <= acc_next;
			b_q <= b_q << 1;
		end
	end

endmodule

`default_nettype wire

// File: ed25519_pkg.sv
`default_nettype none
`include "ed25519_config.svh"

package ed25519_pkg;

	typedef logic [`FE_W-1:0] fe_t;

	// sequencer phases
	typedef enum logic [2:0] {
		IDLE, DOUBLE, ADD, INVERT, AFFINE, EMIT
	} phase_t;

	// a + b mod q, operands below q
	function automatic fe_t fe_add(input fe_t a, input fe_t b);
		logic [`FE_W:0] sum;
		sum = {1'b0, a} + {1'b0, b};
		if (sum >= {1'b0, `FIELD_Q})
		begin
			sum = sum - {1'b0, `FIELD_Q};
		end
		return sum[`FE_W-1:0];
	endfunction

	// a - b mod q
	function automatic fe_t fe_sub(input fe_t a, input fe_t b);
		fe_t diff;
		if (a >= b)
		begin
			diff = a - b;
		end
		else
		begin
			diff = a + (`FIELD_Q - b); // wraps back below q
		end
		return diff;
	endfunction

endpackage

`default_nettype wire

// File: ed25519_config.svh
`ifndef ED25519_CONFIG_SVH
`define ED25519_CONFIG_SVH

// field element width, one spare bit above 2^255
`define FE_W 256

// result stream, x words then y words
`define OUT_W 64
`define OUT_WORDS 8

// q = 2^255 - 19
`define FIELD_Q 256'h7fffffffffffffffffffffffffffffffffffffffffffffffffffffffffffffed
`define CURVE_D 256'h52036cee2b6ffe738cc740797779e89800700a4d4141d8ab75eb4dca135978a3

`define DBL_STEPS 7 // multiplies per doubling
`define ADD_STEPS 11 // multiplies per addition
`define INV_BITS 255 // exponent bits of q - 2

`endif
